/* readout_params.svh */
`ifndef READOUT_PARAMS_SVH
`define READOUT_PARAMS_SVH

// output fifo entries
`define RO_FIFO_DEPTH 16
// frames held in the fe_rx buffer
`define RO_RX_DEPTH 4
`define RO_FRAME_BITS 24
`define RO_ADDR_W 10

// region select on the top two address bits
`define RO_REGION_CMD 2'd0
`define RO_REGION_RX 2'd1
`define RO_REGION_FIFO 2'd2
`define RO_REGION_TLU 2'd3

`endif

/* readout_pkg.sv */
`include "readout_params.svh"

package readout_pkg;

    // host request, copied per region by the decoder
    typedef struct packed {
        logic [`RO_ADDR_W-1:0] paddr;
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [31:0]           pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;  // always high, zero wait
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic        is_trigger;  // 0 for front-end frames
        logic [30:0] body;
    } data_word_t;

    typedef struct packed {
        logic [`RO_FRAME_BITS-1:0] payload;
    } rx_frame_t;

    typedef enum logic {SRC_FE, SRC_TLU} src_sel_t;

    typedef enum logic {CMD_IDLE, CMD_SHIFT} cmd_state_t;

endpackage

/* word_fifo.sv */
`timescale 1ns/10ps

module word_fifo #(
    parameter type item_t = logic [31:0],
    parameter int  DEPTH  = 16
) (
    input  logic                         bus_clk,
    input  logic                         rst_n,
    input  logic                         push,
    input  item_t                        push_data,
    output logic                         full,
    input  logic                         pop,
    output item_t                        pop_data,
    output logic                         empty,
    output logic [$clog2(DEPTH+1)-1:0]   level
);
    localparam int AW = $clog2(DEPTH);

    item_t         mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          do_push;
    logic          do_pop;

    assign full     = level == DEPTH;
    assign empty    = level == 0;
    assign do_push  = push && !full;   // push on full is dropped
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];     // head is visible before the pop

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                level <= level + 1'b1;
            else if (do_pop && !do_push)
                level <= level - 1'b1;
        end
    end

    always_ff @(posedge bus_clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

endmodule

/* fe_rx.sv */
`timescale 1ns/10ps
`include "readout_params.svh"

module fe_rx (
    input  logic                    bus_clk,
    input  logic                    rst_n,
    input  readout_pkg::apb_req_t   apb,
    output readout_pkg::apb_rsp_t   apb_rsp,
    input  logic                    fe_data,
    output logic                    rx_valid,
    output readout_pkg::data_word_t rx_word,
    input  logic                    rx_ready
);
    localparam int CNT_W = $clog2(`RO_FRAME_BITS);

    logic                   enable;
    logic [15:0]            lost_count;
    logic                   busy;        // inside a frame
    logic [CNT_W-1:0]       bit_cnt;
    readout_pkg::rx_frame_t frame_sr;
    logic                   frame_done;  // high the cycle after the last bit
    logic                   buf_full;
    logic                   buf_empty;
    readout_pkg::rx_frame_t head;
    logic                   wr_acc;

    assign wr_acc   = apb.psel && apb.penable && apb.pwrite;
    assign rx_valid = !buf_empty;
    assign rx_word  = '{is_trigger: 1'b0, body: 31'(head.payload)};

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            enable     <= 1'b0;
            busy       <= 1'b0;
            bit_cnt    <= '0;
            frame_done <= 1'b0;
            lost_count <= '0;
        end else begin
            frame_done <= 1'b0;
            if (wr_acc && apb.paddr[7:0] == 8'h00)
                enable <= apb.pwdata[0];
            if (busy) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == CNT_W'(`RO_FRAME_BITS - 1)) begin
                    busy       <= 1'b0;
                    frame_done <= 1'b1;
                end
            end else if (enable && fe_data) begin
                busy    <= 1'b1;  // start bit seen
                bit_cnt <= '0;
            end
            if (wr_acc && apb.paddr[7:0] == 8'h04)
                lost_count <= '0;
            else if (frame_done && buf_full)
                lost_count <= lost_count + 1'b1;
        end
    end

    // payload shifts in msb first
    always_ff @(posedge bus_clk) begin
        if (busy)
            frame_sr.payload <= {frame_sr.payload[`RO_FRAME_BITS-2:0], fe_data};
    end

    word_fifo #(
        .item_t (readout_pkg::rx_frame_t),
        .DEPTH  (`RO_RX_DEPTH)
    ) u_buf (
        .bus_clk   (bus_clk),
        .rst_n     (rst_n),
        .push      (frame_done),
        .push_data (frame_sr),
        .full      (buf_full),
        .pop       (rx_valid && rx_ready),
        .pop_data  (head),
        .empty     (buf_empty),
        .level     ()
    );

    always_comb begin
        apb_rsp = '{prdata: 32'h0, pready: 1'b1, pslverr: 1'b0};
        case (apb.paddr[7:0])
            8'h00:   apb_rsp.prdata = {31'h0, enable};
            8'h04:   apb_rsp.prdata = {16'h0, lost_count};
            default: apb_rsp.pslverr = apb.psel;
        endcase
    end

endmodule

/* tlu_trigger.sv */
`timescale 1ns/10ps

module tlu_trigger (
    input  logic                    bus_clk,
    input  logic                    rst_n,
    input  readout_pkg::apb_req_t   apb,
    output readout_pkg::apb_rsp_t   apb_rsp,
    input  logic                    trig_in,
    output logic                    tlu_busy,
    output logic                    ext_start,
    input  logic                    cmd_ready,
    output logic                    tlu_valid,
    output readout_pkg::data_word_t tlu_word,
    input  logic                    tlu_ready
);
    logic [2:0]  trig_sr;  // two sync flops plus one for the edge
    logic        enable;
    logic        ext_en;
    logic [30:0] trigger_number;
    logic        accept;
    logic        wr_acc;

    assign wr_acc   = apb.psel && apb.penable && apb.pwrite;
    assign accept   = trig_sr[1] && !trig_sr[2] && enable && !tlu_valid;
    assign tlu_busy = tlu_valid;  // busy until the word is taken

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            trig_sr        <= '0;
            enable         <= 1'b0;
            ext_en         <= 1'b0;
            trigger_number <= '0;
            tlu_valid      <= 1'b0;
            ext_start      <= 1'b0;
        end else begin
            trig_sr   <= {trig_sr[1:0], trig_in};
            ext_start <= accept && ext_en && cmd_ready;
            if (accept)
                tlu_valid <= 1'b1;
            else if (tlu_ready)
                tlu_valid <= 1'b0;
            if (wr_acc && apb.paddr[7:0] == 8'h00) begin
                enable <= apb.pwdata[0];
                ext_en <= apb.pwdata[1];
            end
            if (wr_acc && apb.paddr[7:0] == 8'h04)
                trigger_number <= apb.pwdata[30:0];  // host load wins
            else if (accept)
                trigger_number <= trigger_number + 1'b1;
        end
    end

    always_ff @(posedge bus_clk) begin
        if (accept)
            tlu_word <= '{is_trigger: 1'b1, body: trigger_number};
    end

    always_comb begin
        apb_rsp = '{prdata: 32'h0, pready: 1'b1, pslverr: 1'b0};
        case (apb.paddr[7:0])
            8'h00:   apb_rsp.prdata = {30'h0, ext_en, enable};
            8'h04:   apb_rsp.prdata = {1'b0, trigger_number};
            default: apb_rsp.pslverr = apb.psel;
        endcase
    end

endmodule

/* word_arbiter.sv */
`timescale 1ns/10ps

module word_arbiter (
    input  logic                    bus_clk,
    input  logic                    rst_n,
    input  logic                    fe_valid,
    input  readout_pkg::data_word_t fe_word,
    output logic                    fe_ready,
    input  logic                    tlu_valid,
    input  readout_pkg::data_word_t tlu_word,
    output logic                    tlu_ready,
    output logic                    out_valid,
    output readout_pkg::data_word_t out_word,
    input  logic                    out_ready
);
    readout_pkg::src_sel_t last_q;  // source served last
    readout_pkg::src_sel_t hold_src_q;
    logic                  hold_q;  // offered word not yet taken
    readout_pkg::src_sel_t grant;

    always_comb begin
        if (hold_q)
            grant = hold_src_q;
        else if (fe_valid && tlu_valid)
            grant = (last_q == readout_pkg::SRC_FE) ? readout_pkg::SRC_TLU : readout_pkg::SRC_FE;
        else if (tlu_valid)
            grant = readout_pkg::SRC_TLU;
        else
            grant = readout_pkg::SRC_FE;
    end

    assign out_valid = (grant == readout_pkg::SRC_FE) ? fe_valid : tlu_valid;
    assign out_word  = (grant == readout_pkg::SRC_FE) ? fe_word : tlu_word;
    assign fe_ready  = out_ready && grant == readout_pkg::SRC_FE;
    assign tlu_ready = out_ready && grant == readout_pkg::SRC_TLU;

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            last_q     <= readout_pkg::SRC_TLU;  // front end goes first
            hold_src_q <= readout_pkg::SRC_FE;
            hold_q     <= 1'b0;
        end else begin
            hold_q     <= out_valid && !out_ready;
            hold_src_q <= grant;
            if (out_valid && out_ready)
                last_q <= grant;
        end
    end

endmodule

/* out_fifo.sv */
`timescale 1ns/10ps
`include "readout_params.svh"

module out_fifo (
    input  logic                    bus_clk,
    input  logic                    rst_n,
    input  readout_pkg::apb_req_t   apb,
    output readout_pkg::apb_rsp_t   apb_rsp,
    input  logic                    in_valid,
    input  readout_pkg::data_word_t in_word,
    output logic                    in_ready,
    output logic                    fifo_not_empty,
    output logic                    read_error
);
    logic                                fifo_full;
    logic                                fifo_empty;
    logic                                pop;
    logic                                wr_acc;
    readout_pkg::data_word_t             head;
    logic [$clog2(`RO_FIFO_DEPTH+1)-1:0] level;

    assign wr_acc         = apb.psel && apb.penable && apb.pwrite;
    assign pop            = apb.psel && apb.penable && !apb.pwrite && apb.paddr[7:0] == 8'h00;
    assign in_ready       = !fifo_full;
    assign fifo_not_empty = !fifo_empty;

    word_fifo #(
        .item_t (readout_pkg::data_word_t),
        .DEPTH  (`RO_FIFO_DEPTH)
    ) u_fifo (
        .bus_clk   (bus_clk),
        .rst_n     (rst_n),
        .push      (in_valid),
        .push_data (in_word),
        .full      (fifo_full),
        .pop       (pop),
        .pop_data  (head),
        .empty     (fifo_empty),
        .level     (level)
    );

    // sticky until the host writes status
    always_ff @(posedge bus_clk) begin
        if (!rst_n)
            read_error <= 1'b0;
        else if (wr_acc && apb.paddr[7:0] == 8'h04)
            read_error <= 1'b0;
        else if (pop && fifo_empty)
            read_error <= 1'b1;
    end

    always_comb begin
        apb_rsp = '{prdata: 32'h0, pready: 1'b1, pslverr: 1'b0};
        case (apb.paddr[7:0])
            8'h00:   apb_rsp.prdata = fifo_empty ? 32'h0 : head;
            8'h04:   apb_rsp.prdata = {23'h0, read_error, 8'(level)};
            default: apb_rsp.pslverr = apb.psel;
        endcase
    end

endmodule

/* cmd_seq.sv */
`timescale 1ns/10ps

module cmd_seq (
    input  logic                  bus_clk,
    input  logic                  rst_n,
    input  readout_pkg::apb_req_t apb,
    output readout_pkg::apb_rsp_t apb_rsp,
    input  logic                  ext_start,
    output logic                  cmd_data,
    output logic                  cmd_ready
);
    readout_pkg::cmd_state_t state;
    logic [31:0]             cmd_word;
    logic [5:0]              length;     // 1 to 32
    logic [5:0]              bit_cnt;    // bits still to send
    logic [31:0]             shift_reg;
    logic                    wr_acc;
    logic                    start;

    assign wr_acc    = apb.psel && apb.penable && apb.pwrite;
    assign cmd_ready = state == readout_pkg::CMD_IDLE;
    assign start     = cmd_ready && (ext_start || (wr_acc && apb.paddr[7:0] == 8'h08));
    assign cmd_data  = state == readout_pkg::CMD_SHIFT && shift_reg[31];

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            state    <= readout_pkg::CMD_IDLE;
            cmd_word <= '0;
            length   <= 6'd32;
            bit_cnt  <= '0;
        end else begin
            if (wr_acc && apb.paddr[7:0] == 8'h00)
                cmd_word <= apb.pwdata;
            if (wr_acc && apb.paddr[7:0] == 8'h04)
                length <= {apb.pwdata[4:0] == 5'd0, apb.pwdata[4:0]};  // 0 means 32
            if (start) begin
                state   <= readout_pkg::CMD_SHIFT;
                bit_cnt <= length;
            end else if (state == readout_pkg::CMD_SHIFT) begin
                bit_cnt <= bit_cnt - 1'b1;
                if (bit_cnt == 6'd1)
                    state <= readout_pkg::CMD_IDLE;
            end
        end
    end

    // align bit length-1 to the top, then shift out msb first
    always_ff @(posedge bus_clk) begin
        if (start)
            shift_reg <= cmd_word << (6'd32 - length);
        else
            shift_reg <= {shift_reg[30:0], 1'b0};
    end

    always_comb begin
        apb_rsp = '{prdata: 32'h0, pready: 1'b1, pslverr: 1'b0};
        case (apb.paddr[7:0])
            8'h00:   apb_rsp.prdata = cmd_word;
            8'h04:   apb_rsp.prdata = {26'h0, length};
            8'h08:   apb_rsp.prdata = {31'h0, cmd_ready};
            default: apb_rsp.pslverr = apb.psel;
        endcase
    end

endmodule

/* apb_decoder.sv */
`timescale 1ns/10ps
`include "readout_params.svh"

module apb_decoder (
    input  readout_pkg::apb_req_t apb,
    output readout_pkg::apb_rsp_t apb_rsp,
    output readout_pkg::apb_req_t cmd_apb,
    output readout_pkg::apb_req_t rx_apb,
    output readout_pkg::apb_req_t fifo_apb,
    output readout_pkg::apb_req_t tlu_apb,
    input  readout_pkg::apb_rsp_t cmd_rsp,
    input  readout_pkg::apb_rsp_t rx_rsp,
    input  readout_pkg::apb_rsp_t fifo_rsp,
    input  readout_pkg::apb_rsp_t tlu_rsp
);
    logic [1:0] region;

    assign region = apb.paddr[`RO_ADDR_W-1 -: 2];

    always_comb begin
        cmd_apb       = apb;
        rx_apb        = apb;
        fifo_apb      = apb;
        tlu_apb       = apb;
        // one region selected at a time
        cmd_apb.psel  = apb.psel && region == `RO_REGION_CMD;
        rx_apb.psel   = apb.psel && region == `RO_REGION_RX;
        fifo_apb.psel = apb.psel && region == `RO_REGION_FIFO;
        tlu_apb.psel  = apb.psel && region == `RO_REGION_TLU;
    end

    always_comb begin
        case (region)
            `RO_REGION_CMD:  apb_rsp = cmd_rsp;
            `RO_REGION_RX:   apb_rsp = rx_rsp;
            `RO_REGION_FIFO: apb_rsp = fifo_rsp;
            default:         apb_rsp = tlu_rsp;
        endcase
    end

endmodule

/* readout_top.sv */
`timescale 1ns/10ps

module readout_top (
    input  logic                  bus_clk,
    input  logic                  rst_n,
    input  readout_pkg::apb_req_t apb,
    output readout_pkg::apb_rsp_t apb_rsp,
    input  logic                  fe_data,
    input  logic                  trig_in,
    output logic                  tlu_busy,
    output logic                  cmd_data,
    output logic                  cmd_ready,
    output logic                  fifo_not_empty,
    output logic                  read_error
);
    readout_pkg::apb_req_t   cmd_apb, rx_apb, fifo_apb, tlu_apb;
    readout_pkg::apb_rsp_t   cmd_rsp, rx_rsp, fifo_rsp, tlu_rsp;
    logic                    ext_start;
    logic                    rx_valid, rx_ready;
    readout_pkg::data_word_t rx_word;
    logic                    tlu_valid, tlu_ready;
    readout_pkg::data_word_t tlu_word;
    logic                    arb_valid, arb_ready;  // merged stream into the fifo
    readout_pkg::data_word_t arb_word;

    apb_decoder u_dec (
        .apb      (apb),      .apb_rsp  (apb_rsp),
        .cmd_apb  (cmd_apb),  .rx_apb   (rx_apb),
        .fifo_apb (fifo_apb), .tlu_apb  (tlu_apb),
        .cmd_rsp  (cmd_rsp),  .rx_rsp   (rx_rsp),
        .fifo_rsp (fifo_rsp), .tlu_rsp  (tlu_rsp)
    );

    cmd_seq u_cmd (
        .bus_clk   (bus_clk),   .rst_n     (rst_n),
        .apb       (cmd_apb),   .apb_rsp   (cmd_rsp),
        .ext_start (ext_start), .cmd_data  (cmd_data),
        .cmd_ready (cmd_ready)
    );

    fe_rx u_rx (
        .bus_clk  (bus_clk),  .rst_n    (rst_n),
        .apb      (rx_apb),   .apb_rsp  (rx_rsp),
        .fe_data  (fe_data),
        .rx_valid (rx_valid), .rx_word  (rx_word), .rx_ready (rx_ready)
    );

    tlu_trigger u_tlu (
        .bus_clk   (bus_clk),   .rst_n     (rst_n),
        .apb       (tlu_apb),   .apb_rsp   (tlu_rsp),
        .trig_in   (trig_in),   .tlu_busy  (tlu_busy),
        .ext_start (ext_start), .cmd_ready (cmd_ready),
        .tlu_valid (tlu_valid), .tlu_word  (tlu_word), .tlu_ready (tlu_ready)
    );

    word_arbiter u_arb (
        .bus_clk   (bus_clk),   .rst_n     (rst_n),
        .fe_valid  (rx_valid),  .fe_word   (rx_word),  .fe_ready  (rx_ready),
        .tlu_valid (tlu_valid), .tlu_word  (tlu_word), .tlu_ready (tlu_ready),
        .out_valid (arb_valid), .out_word  (arb_word), .out_ready (arb_ready)
    );

    out_fifo u_out (
        .bus_clk        (bus_clk),        .rst_n      (rst_n),
        .apb            (fifo_apb),       .apb_rsp    (fifo_rsp),
        .in_valid       (arb_valid),      .in_word    (arb_word), .in_ready (arb_ready),
        .fifo_not_empty (fifo_not_empty), .read_error (read_error)
    );

endmodule

/* readout_props.sv */
`timescale 1ns/10ps

module readout_props (
    input logic                    bus_clk,
    input logic                    rst_n,
    input logic                    fe_valid,
    input logic                    fe_ready,
    input logic                    tlu_valid,
    input logic                    tlu_ready,
    input logic                    out_valid,
    input logic                    out_ready,
    input readout_pkg::data_word_t out_word
);
    // offered word must not move while the fifo stalls
    a_word_stable: assert property (@(posedge bus_clk) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(out_word))
        else $error("arbiter out_word changed while stalled");

    a_valid_held: assert property (@(posedge bus_clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid)
        else $error("arbiter withdrew out_valid while stalled");

    // after a transfer the waiting source is served next
    a_fe_then_tlu: assert property (@(posedge bus_clk) disable iff (!rst_n)
        fe_valid && fe_ready && tlu_valid |=> !fe_ready)
        else $error("front end served twice with a trigger word waiting");

    a_tlu_then_fe: assert property (@(posedge bus_clk) disable iff (!rst_n)
        tlu_valid && tlu_ready && fe_valid |=> !tlu_ready)
        else $error("trigger source served twice with a front-end word waiting");

endmodule

bind word_arbiter readout_props u_props (
    .bus_clk   (bus_clk),
    .rst_n     (rst_n),
    .fe_valid  (fe_valid),
    .fe_ready  (fe_ready),
    .tlu_valid (tlu_valid),
    .tlu_ready (tlu_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_word  (out_word)
);

/* tb_readout_top.sv */
`timescale 1ns/10ps
`include "readout_params.svh"

module tb_readout_top;
    localparam logic [`RO_ADDR_W-1:0] CMD_WORD  = {`RO_REGION_CMD, 8'h00};
    localparam logic [`RO_ADDR_W-1:0] CMD_LEN   = {`RO_REGION_CMD, 8'h04};
    localparam logic [`RO_ADDR_W-1:0] CMD_START = {`RO_REGION_CMD, 8'h08};
    localparam logic [`RO_ADDR_W-1:0] RX_CTRL   = {`RO_REGION_RX, 8'h00};
    localparam logic [`RO_ADDR_W-1:0] RX_LOST   = {`RO_REGION_RX, 8'h04};
    localparam logic [`RO_ADDR_W-1:0] FIFO_DATA = {`RO_REGION_FIFO, 8'h00};
    localparam logic [`RO_ADDR_W-1:0] FIFO_STAT = {`RO_REGION_FIFO, 8'h04};
    localparam logic [`RO_ADDR_W-1:0] TLU_CTRL  = {`RO_REGION_TLU, 8'h00};
    localparam logic [`RO_ADDR_W-1:0] TLU_NUM   = {`RO_REGION_TLU, 8'h04};

    logic                    bus_clk = 1'b0;
    logic                    rst_n;
    readout_pkg::apb_req_t   apb;
    readout_pkg::apb_rsp_t   apb_rsp;
    logic                    fe_data;
    logic                    trig_in;
    logic                    tlu_busy;
    logic                    cmd_data;
    logic                    cmd_ready;
    logic                    fifo_not_empty;
    logic                    read_error;

    integer                  seed;
    int                      errors;
    int                      timeouts;
    int                      popped;
    int                      feeders;    // stimulus processes still running
    logic [30:0]             next_trig;  // model of trigger_number
    readout_pkg::data_word_t fe_q[$];
    readout_pkg::data_word_t trig_q[$];

    readout_top u_dut (
        .bus_clk        (bus_clk),
        .rst_n          (rst_n),
        .apb            (apb),
        .apb_rsp        (apb_rsp),
        .fe_data        (fe_data),
        .trig_in        (trig_in),
        .tlu_busy       (tlu_busy),
        .cmd_data       (cmd_data),
        .cmd_ready      (cmd_ready),
        .fifo_not_empty (fifo_not_empty),
        .read_error     (read_error)
    );

    always #20 bus_clk = ~bus_clk;

    task automatic check_word(input string name, input readout_pkg::data_word_t got,
                              input readout_pkg::data_word_t exp);
        if (got !== exp) begin
            errors++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_rsp(input string name, input readout_pkg::apb_rsp_t got,
                             input readout_pkg::apb_rsp_t exp);
        if (got !== exp) begin
            errors++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic readout_pkg::apb_rsp_t make_rsp(input logic [31:0] data,
                                                       input logic err);
        readout_pkg::apb_rsp_t r;
        r.prdata  = data;
        r.pready  = 1'b1;
        r.pslverr = err;
        return r;
    endfunction

    // setup cycle, access cycle, response taken mid access
    task automatic apb_xfer(input logic wr, input logic [`RO_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output readout_pkg::apb_rsp_t rsp);
        @(posedge bus_clk);
        apb <= '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: wr, pwdata: wdata};
        @(posedge bus_clk);
        apb.penable <= 1'b1;
        @(negedge bus_clk);
        rsp = apb_rsp;
        @(posedge bus_clk);
        apb <= '0;
    endtask

    task automatic apb_write(input logic [`RO_ADDR_W-1:0] addr, input logic [31:0] wdata);
        readout_pkg::apb_rsp_t rsp;
        apb_xfer(1'b1, addr, wdata, rsp);
    endtask

    task automatic send_frame(input logic [`RO_FRAME_BITS-1:0] payload, input int gap);
        readout_pkg::data_word_t w;
        w.is_trigger = 1'b0;
        w.body       = 31'(payload);
        fe_q.push_back(w);
        @(posedge bus_clk);
        fe_data <= 1'b1;  // start bit
        for (int i = `RO_FRAME_BITS - 1; i >= 0; i--) begin
            @(posedge bus_clk);
            fe_data <= payload[i];
        end
        @(posedge bus_clk);
        fe_data <= 1'b0;
        repeat (gap) @(posedge bus_clk);
    endtask

    // raise trig_in and hold it until busy shows up
    task automatic fire_trigger();
        readout_pkg::data_word_t w;
        int                      k;
        k = 0;
        @(negedge bus_clk);
        while (tlu_busy && k < 200) begin
            @(negedge bus_clk);
            k++;
        end
        if (tlu_busy) begin
            timeouts++;
            $display("timeout: tlu_busy stayed high before a trigger pulse");
        end
        w.is_trigger = 1'b1;
        w.body       = next_trig;
        trig_q.push_back(w);
        next_trig = next_trig + 1'b1;
        @(posedge bus_clk);
        trig_in <= 1'b1;
        k = 0;
        do begin
            @(negedge bus_clk);
            k++;
        end while (!tlu_busy && k < 4);  // two sync flops plus edge detect
        if (!tlu_busy) begin
            timeouts++;
            $display("timeout: tlu_busy did not rise within 3 cycles of a trigger pulse");
        end
        @(posedge bus_clk);
        trig_in <= 1'b0;
    endtask

    task automatic check_cmd_stream(input logic [31:0] word, input int len);
        int wait_cnt;
        int nbits;
        wait_cnt = 0;
        nbits    = 0;
        @(negedge bus_clk);
        while (cmd_ready && wait_cnt < 20) begin
            @(negedge bus_clk);
            wait_cnt++;
        end
        if (cmd_ready) begin
            timeouts++;
            $display("timeout: cmd_ready never fell after a command start");
        end else begin
            while (!cmd_ready && nbits < 40) begin
                if (nbits < len)
                    check_bit("cmd_data", cmd_data, word[len-1-nbits]);  // msb first
                nbits++;
                @(negedge bus_clk);
            end
            check_count("cmd bit count", nbits, len);
        end
    endtask

    task automatic pop_word();
        readout_pkg::apb_rsp_t   rsp;
        readout_pkg::data_word_t w;
        apb_xfer(1'b0, FIFO_DATA, 32'h0, rsp);
        w = readout_pkg::data_word_t'(rsp.prdata);
        popped++;
        check_bit("pslverr", rsp.pslverr, 1'b0);
        if (w.is_trigger && trig_q.size() == 0) begin
            errors++;
            $display("trigger word %h popped with none outstanding", w);
        end else if (w.is_trigger) begin
            check_word("trigger word", w, trig_q.pop_front());
        end else if (fe_q.size() == 0) begin
            errors++;
            $display("front-end word %h popped with none outstanding", w);
        end else begin
            check_word("front-end word", w, fe_q.pop_front());
        end
    endtask

    // pops while sources run, then until the fifo stays empty
    task automatic pop_until_idle();
        int idle;
        int guard;
        idle  = 0;
        guard = 0;
        while ((feeders > 0 || idle < 40) && guard < 20000) begin
            @(negedge bus_clk);
            guard++;
            if (fifo_not_empty) begin
                pop_word();
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (guard >= 20000) begin
            timeouts++;
            $display("timeout: output fifo never drained");
        end
    endtask

    initial begin
        readout_pkg::apb_rsp_t rsp;
        logic [31:0]           word;
        int                    len;
        int                    base;
        int                    sent;
        int                    lost;
        seed     = 32'hfba1;
        errors   = 0;
        timeouts = 0;
        popped   = 0;
        feeders  = 0;
        apb      = '0;
        fe_data  = 1'b0;
        trig_in  = 1'b0;
        rst_n    = 1'b0;
        repeat (3) @(posedge bus_clk);
        rst_n <= 1'b1;
        @(negedge bus_clk);
        check_bit("cmd_ready", cmd_ready, 1'b1);
        check_bit("cmd_data", cmd_data, 1'b0);
        check_bit("tlu_busy", tlu_busy, 1'b0);
        check_bit("read_error", read_error, 1'b0);
        check_bit("fifo_not_empty", fifo_not_empty, 1'b0);

        // host launched commands
        repeat (6) begin
            word = $random(seed);
            len  = rand_range(1, 32);
            apb_write(CMD_WORD, word);
            apb_write(CMD_LEN, 32'(len));
            apb_write(CMD_START, 32'h0);
            check_cmd_stream(word, len);
        end

        // front-end frames with a paced reader
        apb_write(RX_CTRL, 32'h1);
        feeders = 1;
        fork
            begin
                repeat (10) send_frame(24'($random(seed)), rand_range(1, 12));
                feeders--;
            end
            pop_until_idle();
        join

        // triggers, then triggers launching the command
        next_trig = 31'($random(seed));
        apb_write(TLU_NUM, {1'b0, next_trig});
        apb_write(TLU_CTRL, 32'h1);
        repeat (4) begin
            fire_trigger();
            repeat (rand_range(5, 20)) @(posedge bus_clk);
        end
        apb_write(TLU_CTRL, 32'h3);
        repeat (4) begin
            word = $random(seed);
            len  = rand_range(1, 32);
            apb_write(CMD_WORD, word);
            apb_write(CMD_LEN, 32'(len));
            fire_trigger();
            check_cmd_stream(word, len);
            repeat (rand_range(5, 20)) @(posedge bus_clk);
        end
        pop_until_idle();
        apb_xfer(1'b0, TLU_NUM, 32'h0, rsp);
        check_rsp("trigger_number", rsp, make_rsp({1'b0, next_trig}, 1'b0));

        // both sources at once
        apb_write(TLU_CTRL, 32'h1);
        base    = popped;
        feeders = 2;
        fork
            begin
                repeat (12) send_frame(24'($random(seed)), rand_range(1, 10));
                feeders--;
            end
            begin
                repeat (10) begin
                    repeat (rand_range(15, 50)) @(posedge bus_clk);
                    fire_trigger();
                end
                feeders--;
            end
            pop_until_idle();
        join
        apb_xfer(1'b0, RX_LOST, 32'h0, rsp);
        lost = rsp.prdata;
        check_count("popped words", popped - base, 12 - lost + 10);
        check_count("trigger words left", trig_q.size(), 0);

        // overflow with no reader; the tail frames are the lost ones
        sent = 0;
        lost = 0;
        while (lost == 0 && sent < 40) begin
            send_frame(24'($random(seed)), 2);
            sent++;
            apb_xfer(1'b0, RX_LOST, 32'h0, rsp);
            lost = rsp.prdata;
        end
        check_rsp("lost_count", rsp,
                  make_rsp(32'(sent - `RO_FIFO_DEPTH - `RO_RX_DEPTH), 1'b0));
        pop_until_idle();
        check_count("frames never popped", fe_q.size(), lost);
        fe_q.delete();
        apb_write(RX_LOST, 32'h0);

        // empty pop, sticky error, unmapped offsets
        apb_xfer(1'b0, FIFO_DATA, 32'h0, rsp);
        check_rsp("empty pop", rsp, make_rsp(32'h0, 1'b0));
        @(negedge bus_clk);
        check_bit("read_error", read_error, 1'b1);
        apb_xfer(1'b0, FIFO_STAT, 32'h0, rsp);
        check_rsp("fifo status", rsp, make_rsp(32'h100, 1'b0));
        apb_write(FIFO_STAT, 32'h0);
        @(negedge bus_clk);
        check_bit("read_error", read_error, 1'b0);
        apb_xfer(1'b0, {`RO_REGION_CMD, 8'h0c}, 32'h0, rsp);
        check_rsp("unmapped cmd", rsp, make_rsp(32'h0, 1'b1));
        apb_xfer(1'b0, {`RO_REGION_RX, 8'h08}, 32'h0, rsp);
        check_rsp("unmapped rx", rsp, make_rsp(32'h0, 1'b1));
        apb_xfer(1'b0, {`RO_REGION_FIFO, 8'h08}, 32'h0, rsp);
        check_rsp("unmapped fifo", rsp, make_rsp(32'h0, 1'b1));

        $display("result: %0d value errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+.
readout_pkg.sv
word_fifo.sv
fe_rx.sv
tlu_trigger.sv
word_arbiter.sv
out_fifo.sv
cmd_seq.sv
apb_decoder.sv
readout_top.sv
readout_props.sv
tb_readout_top.sv

/* Makefile */
SRCS := $(shell grep '\.sv$$' vlog.f) readout_params.svh

all: run

obj_dir/Vtb_readout_top: $(SRCS) vlog.f
	verilator --binary --timing --assert -f vlog.f --top-module tb_readout_top -Mdir obj_dir

run: obj_dir/Vtb_readout_top
	./obj_dir/Vtb_readout_top | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
